// File: src/link_rx_config.svh
/* link receiver configuration macros
   lane widths, sync pattern, board shape and skew timeout */

`ifndef LINK_RX_CONFIG_SVH
`define LINK_RX_CONFIG_SVH

// data wires, one lane word each per frame
`define LINK_DATA_LANES 4

// payload bits per data lane
`define LINK_LANE_BITS 16

// sync pattern, shared by every wire
`define LINK_SYNC_BITS 8
`define LINK_SYNC_WORD 8'hA5

// handshake header payload
`define LINK_HEAD_BITS 8

// cycles from first lane valid until a partial frame is flushed
`define LINK_SKEW_TIMEOUT 64

// opponent board shape
`define LINK_QUEUE_LEN 3
`define LINK_ROWS 2
`define LINK_COLS 5

`endif

// File: src/game_pkg.sv
/* game side types
   tile codes, garbage count, piece queue and playfield */

`include "link_rx_config.svh"

package game_pkg;

	// 4-bit tile code
	typedef logic [3:0] tile_t;

	// empty cell
	localparam tile_t BLANK = 4'd0;

	// incoming garbage lines
	typedef logic [3:0] garbage_t;

	// next pieces, entry 0 in the top bits
	typedef tile_t [0:`LINK_QUEUE_LEN-1] piece_queue_t;

	// row 0 first, column 0 first within a row
	typedef tile_t [0:`LINK_ROWS-1][0:`LINK_COLS-1] playfield_t;

endpackage

// File: src/link_pkg.sv
/* wire protocol types
   lane words, data packet layout and handshake header */

`include "link_rx_config.svh"

package link_pkg;

	import game_pkg::*;

	// payload of one data wire
	typedef logic [`LINK_LANE_BITS-1:0] lane_word_t;

	// all lane words concatenated, lane 0 in the top bits
	// 4 + 4 + 4 + 12 + 40 = 64 bits
	typedef struct packed {
		// one copy of the sequence bit per lane, majority wins
		logic [`LINK_DATA_LANES-1:0] seq_vote;
		garbage_t garbage;
		tile_t hold;
		piece_queue_t queue;
		playfield_t playfield;
	} data_pkt_t;

	// handshake header
	// pid/pid_n = 1/0 is an ack, 0/1 is game end
	typedef struct packed {
		logic pid;
		logic pid_n;
		logic ack_seq;
		logic [`LINK_HEAD_BITS-4:0] spare;
	} hnd_head_t;

endpackage

// File: src/lane_deserializer.sv
/* single wire receiver
   sync word hunt, payload shift-in, word held until accepted */

`timescale 1ns/1ps

`include "link_rx_config.svh"

module lane_deserializer #(
	parameter type payload_t = logic [`LINK_LANE_BITS-1:0]
) (
	input  logic     clk,
	input  logic     rst_l,
	input  logic     game_active,
	input  logic     serial_in,
	output logic     word_valid,
	input  logic     word_ready,
	output payload_t word
);

	localparam int W     = $bits(payload_t);
	localparam int CNT_W = (W > 1) ? $clog2(W) : 1;

	typedef enum logic [1:0] {
		HUNT,
		SHIFT,
		HOLD
	} state_t;

	state_t state;
	logic [`LINK_SYNC_BITS-1:0] sync_sr;
	logic [`LINK_SYNC_BITS-1:0] sync_next;
	logic [CNT_W-1:0] bit_cnt;
	logic [W-1:0] shreg;

	// window including the bit on the wire right now
	assign sync_next = {sync_sr[`LINK_SYNC_BITS-2:0], serial_in};

	assign word_valid = (state == HOLD);
	assign word = payload_t'(shreg);

	// control state
	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			state   <= HUNT;
			sync_sr <= '0;
			bit_cnt <= '0;
		end else if (!game_active) begin
			state   <= HUNT;
			sync_sr <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				HUNT: begin
					sync_sr <= sync_next;
					// last sync bit sampled now, payload starts next cycle
					if (sync_next == `LINK_SYNC_WORD) begin
						state   <= SHIFT;
						bit_cnt <= '0;
					end
				end
				SHIFT: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(W - 1)) begin
						state <= HOLD;
					end
				end
				HOLD: begin
					// accepted, forget the old sync window
					if (word_ready) begin
						state   <= HUNT;
						sync_sr <= '0;
					end
				end
				default: begin
					state <= HUNT;
				end
			endcase
		end
	end

	// payload, msb first
	always_ff @(posedge clk) begin
		if (state == SHIFT) begin
			shreg <= {shreg[W-2:0], serial_in};
		end
	end

endmodule

// File: src/frame_ctrl.sv
/* frame controller
   joins lane valids into one frame, pops lanes, flushes skewed frames */

`timescale 1ns/1ps

`include "link_rx_config.svh"

module frame_ctrl (
	input  logic                        clk,
	input  logic                        rst_l,
	input  logic                        game_active,
	input  logic [`LINK_DATA_LANES-1:0] lane_valid,
	output logic [`LINK_DATA_LANES-1:0] lane_pop,
	output logic                        frame_valid,
	input  logic                        frame_ready,
	output logic [7:0]                  frame_drops
);

	localparam int SKEW_W = $clog2(`LINK_SKEW_TIMEOUT + 1);

	logic all_valid;
	logic any_valid;
	logic accept;
	logic flush;
	logic [SKEW_W-1:0] skew_cnt;

	assign all_valid = &lane_valid;
	assign any_valid = |lane_valid;
	assign accept = frame_valid & frame_ready;

	// some lanes done, others silent for too long
	assign flush = any_valid & ~all_valid &
		(skew_cnt == SKEW_W'(`LINK_SKEW_TIMEOUT));

	// full frame pops all lanes, flush only the ones holding a word
	always_comb begin
		if (accept) begin
			lane_pop = '1;
		end else if (flush) begin
			lane_pop = lane_valid;
		end else begin
			lane_pop = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			frame_valid <= 1'b0;
			skew_cnt    <= '0;
			frame_drops <= '0;
		end else if (!game_active) begin
			frame_valid <= 1'b0;
			skew_cnt    <= '0;
			frame_drops <= '0;
		end else begin
			// one cycle after the last lane; lanes hold while back-pressured
			frame_valid <= all_valid & ~accept;
			// runs only while the frame is incomplete
			if (!any_valid || all_valid || flush) begin
				skew_cnt <= '0;
			end else begin
				skew_cnt <= skew_cnt + 1'b1;
			end
			if (flush) begin
				frame_drops <= frame_drops + 1'b1;
			end
		end
	end

endmodule

// File: src/packet_assembler.sv
/* packet assembler
   sequence vote, duplicate drop, board unpack, update output and ack request */

`timescale 1ns/1ps

`include "link_rx_config.svh"

module packet_assembler (
	input  logic                    clk,
	input  logic                    rst_l,
	input  logic                    game_active,
	input  link_pkg::lane_word_t    lane_words [`LINK_DATA_LANES],
	input  logic                    frame_valid,
	output logic                    frame_ready,
	output logic                    upd_valid,
	input  logic                    upd_ready,
	output game_pkg::garbage_t      opp_garbage,
	output game_pkg::tile_t         opp_hold,
	output game_pkg::piece_queue_t  opp_queue,
	output game_pkg::playfield_t    opp_playfield,
	output logic                    ack_req,
	output logic                    ack_seq,
	output logic [7:0]              packets_received
);

	import link_pkg::*;
	import game_pkg::*;

	logic [`LINK_DATA_LANES*`LINK_LANE_BITS-1:0] pkt_bits;
	data_pkt_t pkt;
	logic accept;
	logic rx_seq;
	logic exp_seq;

	// lane 0 lands in the top bits
	always_comb begin
		for (int i = 0; i < `LINK_DATA_LANES; i++) begin
			pkt_bits[(`LINK_DATA_LANES-1-i)*`LINK_LANE_BITS +: `LINK_LANE_BITS] = lane_words[i];
		end
	end

	assign pkt = data_pkt_t'(pkt_bits);

	// majority of the per-lane copies, a single flipped bit is outvoted
	assign rx_seq = ($countones(pkt.seq_vote) >= 2);

	// stall the frame in the lanes while the game logic has not taken the update
	assign frame_ready = ~(upd_valid & ~upd_ready);
	assign accept = frame_valid & frame_ready;

	// sequence bit expected next, already advanced on a new packet
	assign ack_seq = exp_seq;

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			upd_valid        <= 1'b0;
			ack_req          <= 1'b0;
			exp_seq          <= 1'b0;
			packets_received <= '0;
			opp_garbage      <= '0;
			opp_hold         <= BLANK;
			opp_queue        <= {`LINK_QUEUE_LEN{BLANK}};
			opp_playfield    <= {(`LINK_ROWS*`LINK_COLS){BLANK}};
		end else if (!game_active) begin
			upd_valid        <= 1'b0;
			ack_req          <= 1'b0;
			exp_seq          <= 1'b0;
			packets_received <= '0;
			opp_garbage      <= '0;
			opp_hold         <= BLANK;
			opp_queue        <= {`LINK_QUEUE_LEN{BLANK}};
			opp_playfield    <= {(`LINK_ROWS*`LINK_COLS){BLANK}};
		end else begin
			// ack every accepted frame, duplicates too
			ack_req <= accept;
			if (upd_valid && upd_ready) begin
				upd_valid <= 1'b0;
			end
			// new sequence number, take the board
			if (accept && (rx_seq == exp_seq)) begin
				upd_valid        <= 1'b1;
				exp_seq          <= ~exp_seq;
				packets_received <= packets_received + 1'b1;
				opp_garbage      <= pkt.garbage;
				opp_hold         <= pkt.hold;
				opp_queue        <= pkt.queue;
				opp_playfield    <= pkt.playfield;
			end
		end
	end

endmodule

// File: src/handshake_decoder.sv
/* handshake header decoder
   ack pulses with their sequence bit, sticky opponent-lost flag */

`timescale 1ns/1ps

module handshake_decoder (
	input  logic                clk,
	input  logic                rst_l,
	input  logic                game_active,
	input  logic                head_valid,
	output logic                head_ready,
	input  link_pkg::hnd_head_t head,
	output logic                ack_received,
	output logic                ack_received_seq,
	output logic                opponent_lost,
	output logic [7:0]          acks_received
);

	logic accept;
	logic busy;
	logic is_ack;
	logic is_lost;

	// not ready in the cycle that reports the last header
	assign head_ready = ~busy;
	assign accept = head_valid & head_ready;

	// pid pair decode, anything else ignored
	assign is_ack  = head.pid & ~head.pid_n;
	assign is_lost = ~head.pid & head.pid_n;

	always_ff @(posedge clk or negedge rst_l) begin
		if (!rst_l) begin
			busy             <= 1'b0;
			ack_received     <= 1'b0;
			ack_received_seq <= 1'b0;
			opponent_lost    <= 1'b0;
			acks_received    <= '0;
		end else if (!game_active) begin
			busy             <= 1'b0;
			ack_received     <= 1'b0;
			ack_received_seq <= 1'b0;
			opponent_lost    <= 1'b0;
			acks_received    <= '0;
		end else begin
			busy         <= accept;
			ack_received <= accept & is_ack;
			if (accept && is_ack) begin
				ack_received_seq <= head.ack_seq;
				acks_received    <= acks_received + 1'b1;
			end
			// sticky until the game ends
			if (accept && is_lost) begin
				opponent_lost <= 1'b1;
			end
		end
	end

endmodule

// File: src/link_rx_top.sv
/* link receiver top
   data lanes, handshake lane, frame controller, assembler and decoder */

`timescale 1ns/1ps

`include "link_rx_config.svh"

module link_rx_top (
	input  logic                        clk,
	input  logic                        rst_l,
	input  logic                        game_active,
	input  logic [`LINK_DATA_LANES-1:0] serial_data,
	input  logic                        serial_hnd,
	output logic                        upd_valid,
	input  logic                        upd_ready,
	output game_pkg::garbage_t          opp_garbage,
	output game_pkg::tile_t             opp_hold,
	output game_pkg::piece_queue_t      opp_queue,
	output game_pkg::playfield_t        opp_playfield,
	output logic                        ack_req,
	output logic                        ack_seq,
	output logic                        ack_received,
	output logic                        ack_received_seq,
	output logic                        opponent_lost,
	output logic [7:0]                  packets_received,
	output logic [7:0]                  acks_received,
	output logic [7:0]                  frame_drops
);

	import link_pkg::*;

	// data lanes
	lane_word_t lane_words [`LINK_DATA_LANES];
	logic [`LINK_DATA_LANES-1:0] lane_valid;
	logic [`LINK_DATA_LANES-1:0] lane_pop;
	logic frame_valid;
	logic frame_ready;

	// handshake lane
	hnd_head_t hnd_head;
	logic hnd_valid;
	logic hnd_ready;

	for (genvar i = 0; i < `LINK_DATA_LANES; i++) begin : g_lane
		lane_deserializer #(
			.payload_t(lane_word_t)
		) i_lane_deserializer (
			.clk        (clk),
			.rst_l      (rst_l),
			.game_active(game_active),
			.serial_in  (serial_data[i]),
			.word_valid (lane_valid[i]),
			.word_ready (lane_pop[i]),
			.word       (lane_words[i])
		);
	end

	// same receiver, header sized payload
	lane_deserializer #(
		.payload_t(hnd_head_t)
	) i_hnd_deserializer (
		.clk        (clk),
		.rst_l      (rst_l),
		.game_active(game_active),
		.serial_in  (serial_hnd),
		.word_valid (hnd_valid),
		.word_ready (hnd_ready),
		.word       (hnd_head)
	);

	frame_ctrl i_frame_ctrl (
		.clk        (clk),
		.rst_l      (rst_l),
		.game_active(game_active),
		.lane_valid (lane_valid),
		.lane_pop   (lane_pop),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.frame_drops(frame_drops)
	);

	packet_assembler i_packet_assembler (
		.clk             (clk),
		.rst_l           (rst_l),
		.game_active     (game_active),
		.lane_words      (lane_words),
		.frame_valid     (frame_valid),
		.frame_ready     (frame_ready),
		.upd_valid       (upd_valid),
		.upd_ready       (upd_ready),
		.opp_garbage     (opp_garbage),
		.opp_hold        (opp_hold),
		.opp_queue       (opp_queue),
		.opp_playfield   (opp_playfield),
		.ack_req         (ack_req),
		.ack_seq         (ack_seq),
		.packets_received(packets_received)
	);

	handshake_decoder i_handshake_decoder (
		.clk             (clk),
		.rst_l           (rst_l),
		.game_active     (game_active),
		.head_valid      (hnd_valid),
		.head_ready      (hnd_ready),
		.head            (hnd_head),
		.ack_received    (ack_received),
		.ack_received_seq(ack_received_seq),
		.opponent_lost   (opponent_lost),
		.acks_received   (acks_received)
	);

endmodule

// File: test/link_rx_asserts.sv
/* protocol assertions for the link receiver top
   update hold under back-pressure, ack pulse width, idle outputs */

`timescale 1ns/1ps

module link_rx_asserts (
	input logic                   clk,
	input logic                   rst_l,
	input logic                   game_active,
	input logic                   upd_valid,
	input logic                   upd_ready,
	input game_pkg::garbage_t     opp_garbage,
	input game_pkg::tile_t        opp_hold,
	input game_pkg::piece_queue_t opp_queue,
	input game_pkg::playfield_t   opp_playfield,
	input logic                   ack_req,
	input logic                   ack_seq,
	input logic                   ack_received,
	input logic                   opponent_lost,
	input logic [7:0]             packets_received,
	input logic [7:0]             acks_received,
	input logic [7:0]             frame_drops
);

	// update and board frozen until the game logic takes them
	assert property (@(posedge clk) disable iff (!rst_l || !game_active)
		upd_valid && !upd_ready |=> upd_valid && $stable(opp_garbage) && $stable(opp_hold)
			&& $stable(opp_queue) && $stable(opp_playfield))
	else $error("update dropped or board changed while upd_ready low");

	// sender samples a single-cycle pulse
	assert property (@(posedge clk) disable iff (!rst_l) ack_req |=> !ack_req)
	else $error("ack_req longer than one cycle");

	// game over, everything back to reset values
	assert property (@(posedge clk) disable iff (!rst_l)
		!game_active |=> !upd_valid && !ack_req && !ack_seq && !ack_received && !opponent_lost
			&& packets_received == 8'd0 && acks_received == 8'd0 && frame_drops == 8'd0
			&& opp_garbage == '0 && opp_hold == '0 && opp_queue == '0 && opp_playfield == '0)
	else $error("outputs not idle while game_active low");

endmodule

// File: test/link_rx_tb.sv
/* link receiver testbench
   serial wire driver, reference model, compare tasks, watchdog and summary */

`timescale 1ns/1ps

`include "link_rx_config.svh"

module link_rx_tb;

	import game_pkg::*;
	import link_pkg::*;

	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 2000;
	localparam int WAIT_LIMIT  = 500;
	localparam int MAX_SKEW    = 40;
	localparam int HND         = `LINK_DATA_LANES;

	logic                        clk;
	logic                        rst_l;
	logic                        game_active;
	logic [`LINK_DATA_LANES-1:0] serial_data;
	logic                        serial_hnd;
	logic                        upd_valid;
	logic                        upd_ready;
	garbage_t                    opp_garbage;
	tile_t                       opp_hold;
	piece_queue_t                opp_queue;
	playfield_t                  opp_playfield;
	logic                        ack_req;
	logic                        ack_seq;
	logic                        ack_received;
	logic                        ack_received_seq;
	logic                        opponent_lost;
	logic [7:0]                  packets_received;
	logic [7:0]                  acks_received;
	logic [7:0]                  frame_drops;

	// per wire bit queues, code 2 means one noise bit
	logic [1:0] bitq [`LINK_DATA_LANES+1][$];
	logic [`LINK_SYNC_BITS-1:0] hist [`LINK_DATA_LANES+1];

	// reference model
	data_pkt_t exp_upd [$];
	logic exp_ack [$];
	logic exp_hnd [$];
	logic m_exp_seq;
	logic m_lost;
	int m_pkts;
	int m_drops;
	int m_acks;

	// observed events
	int ack_reqs;
	int ack_pulses;
	int upd_seen;

	int errors;
	int err_at_start;
	int tests_run;
	int tests_failed;
	string cur_name;
	bit stall_en;
	int stall_left;

	link_rx_top i_link_rx_top (.*);

	bind link_rx_top link_rx_asserts i_link_rx_asserts (.*);

	always #5 clk = ~clk;

	function automatic data_pkt_t make_pkt(input logic s, input bit flip);
		data_pkt_t p;
		int k;
		p = data_pkt_t'({$urandom, $urandom});
		p.seq_vote = {`LINK_DATA_LANES{s}};
		// one lane disagrees, majority still holds
		if (flip) begin
			k = $urandom_range(0, `LINK_DATA_LANES - 1);
			p.seq_vote[k] = ~p.seq_vote[k];
		end
		return p;
	endfunction

	function automatic logic voted_seq(input logic [`LINK_DATA_LANES-1:0] v);
		int ones;
		ones = 0;
		for (int i = 0; i < `LINK_DATA_LANES; i++) begin
			ones += v[i];
		end
		return (ones >= 2);
	endfunction

	task automatic note_failure(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_update(input garbage_t g, input garbage_t eg, input tile_t h,
		input tile_t eh, input piece_queue_t q, input piece_queue_t eq,
		input playfield_t p, input playfield_t ep);
		if (g !== eg) begin
			errors++;
			$display("Mismatch at %0t: opp_garbage got %h expected %h", $time, g, eg);
		end
		if (h !== eh) begin
			errors++;
			$display("Mismatch at %0t: opp_hold got %h expected %h", $time, h, eh);
		end
		if (q !== eq) begin
			errors++;
			$display("Mismatch at %0t: opp_queue got %h expected %h", $time, q, eq);
		end
		if (p !== ep) begin
			errors++;
			$display("Mismatch at %0t: opp_playfield got %h expected %h", $time, p, ep);
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] act, input logic [7:0] exp);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, act, exp);
		end
	endtask

	task automatic check_counts();
		check_count("packets_received", packets_received, m_pkts[7:0]);
		check_count("upd_valid count", upd_seen[7:0], m_pkts[7:0]);
		check_count("frame_drops", frame_drops, m_drops[7:0]);
		check_count("acks_received", acks_received, m_acks[7:0]);
		check_flag("opponent_lost", opponent_lost, m_lost);
	endtask

	task automatic push_bits(input int w, input logic [31:0] v, input int n);
		for (int k = n - 1; k >= 0; k--) begin
			bitq[w].push_back({1'b0, v[k]});
		end
	endtask

	// noise of random length, zero guard, then the sync word
	task automatic push_preamble(input int w);
		repeat ($urandom_range(0, MAX_SKEW)) bitq[w].push_back(2'd2);
		repeat (`LINK_SYNC_BITS) bitq[w].push_back(2'd0);
		push_bits(w, `LINK_SYNC_WORD, `LINK_SYNC_BITS);
	endtask

	task automatic send_frame(input data_pkt_t pkt, input int silent);
		logic [`LINK_DATA_LANES*`LINK_LANE_BITS-1:0] raw;
		raw = pkt;
		for (int i = 0; i < `LINK_DATA_LANES; i++) begin
			if (i != silent) begin
				push_preamble(i);
				push_bits(i, raw[(`LINK_DATA_LANES-1-i)*`LINK_LANE_BITS +: `LINK_LANE_BITS],
					`LINK_LANE_BITS);
			end
		end
	endtask

	function automatic int progress(input string what);
		case (what)
			"ack_req":       return ack_reqs;
			"ack_received":  return ack_pulses;
			"update":        return upd_seen;
			"frame_drops":   return frame_drops;
			"opponent_lost": return opponent_lost;
			default:         return (bitq[HND].size() == 0) ? 1 : 0;
		endcase
	endfunction

	task automatic wait_for(input string what, input int target);
		int n;
		n = 0;
		while (progress(what) < target && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (progress(what) < target) begin
			note_failure($sformatf("timed out waiting for %s", what));
		end
	endtask

	// full frame waits for its ack, a partial one for the flush
	task automatic send_and_wait(input data_pkt_t pkt, input int silent);
		int target;
		if (silent < 0) begin
			target = ack_reqs + 1;
			if (voted_seq(pkt.seq_vote) == m_exp_seq) begin
				exp_upd.push_back(pkt);
				m_exp_seq = ~m_exp_seq;
				m_pkts++;
			end
			exp_ack.push_back(m_exp_seq);
			send_frame(pkt, silent);
			wait_for("ack_req", target);
		end else begin
			m_drops++;
			send_frame(pkt, silent);
			wait_for("frame_drops", m_drops);
		end
	endtask

	task automatic send_head(input logic pid, input logic pid_n, input logic s);
		hnd_head_t h;
		int target;
		h.pid = pid;
		h.pid_n = pid_n;
		h.ack_seq = s;
		h.spare = $urandom;
		push_preamble(HND);
		push_bits(HND, h, `LINK_HEAD_BITS);
		if (pid && !pid_n) begin
			target = ack_pulses + 1;
			exp_hnd.push_back(s);
			m_acks++;
			wait_for("ack_received", target);
		end else if (!pid && pid_n) begin
			m_lost = 1'b1;
			wait_for("opponent_lost", 1);
		end else begin
			// ignored header, decode latency is fixed
			wait_for("hnd_drained", 1);
			repeat (4) @(negedge clk);
		end
	endtask

	task automatic begin_test(input string name);
		cur_name = name;
		err_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > err_at_start) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, cur_name, errors - err_at_start);
		end else begin
			$display("test %0d %s: ok", tests_run, cur_name);
		end
	endtask

	// wire driver, noise never completes the sync word
	always @(negedge clk) begin : drive_wires
		logic [`LINK_DATA_LANES:0] bits;
		logic [1:0] code;
		logic b;
		for (int w = 0; w <= `LINK_DATA_LANES; w++) begin
			code = (bitq[w].size() != 0) ? bitq[w].pop_front() : 2'd2;
			if (code == 2'd2) begin
				b = $urandom_range(0, 1);
				if ({hist[w][`LINK_SYNC_BITS-2:0], b} == `LINK_SYNC_WORD) begin
					b = ~b;
				end
			end else begin
				b = code[0];
			end
			hist[w] = {hist[w][`LINK_SYNC_BITS-2:0], b};
			bits[w] = b;
		end
		serial_data <= bits[`LINK_DATA_LANES-1:0];
		serial_hnd <= bits[HND];
	end

	// game logic back-pressure in random stretches
	always @(negedge clk) begin : drive_ready
		if (!stall_en) begin
			upd_ready <= 1'b1;
		end else if (stall_left == 0) begin
			upd_ready <= $urandom_range(0, 1);
			stall_left = $urandom_range(1, 24);
		end else begin
			stall_left--;
		end
	end

	always @(posedge clk) begin : watch_outputs
		data_pkt_t e;
		if (rst_l && game_active) begin
			if (upd_valid && upd_ready) begin
				upd_seen++;
				if (exp_upd.size() == 0) begin
					note_failure("update delivered with no new packet outstanding");
				end else begin
					e = exp_upd.pop_front();
					check_update(opp_garbage, e.garbage, opp_hold, e.hold, opp_queue, e.queue,
						opp_playfield, e.playfield);
				end
			end
			if (ack_req) begin
				ack_reqs++;
				if (exp_ack.size() == 0) begin
					note_failure("ack_req raised with no frame outstanding");
				end else begin
					check_flag("ack_seq", ack_seq, exp_ack.pop_front());
				end
			end
			if (ack_received) begin
				ack_pulses++;
				if (exp_hnd.size() == 0) begin
					note_failure("ack_received pulsed with no ack header sent");
				end else begin
					check_flag("ack_received_seq", ack_received_seq, exp_hnd.pop_front());
				end
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_TESTS * TEST_CYCLES + 1000) @(posedge clk);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end

	initial begin : run_tests
		void'($urandom(12));
		clk = 1'b0;
		rst_l = 1'b0;
		game_active = 1'b0;
		serial_data = '0;
		serial_hnd = 1'b0;
		upd_ready = 1'b1;
		stall_en = 1'b0;
		stall_left = 0;
		m_exp_seq = 1'b0;
		m_lost = 1'b0;
		for (int w = 0; w <= `LINK_DATA_LANES; w++) begin
			hist[w] = '0;
		end
		repeat (8) @(negedge clk);
		rst_l = 1'b1;
		@(negedge clk);
		game_active = 1'b1;
		repeat (4) @(negedge clk);

		begin_test("in-order packets with vote flips");
		for (int i = 0; i < 8; i++) begin
			send_and_wait(make_pkt(m_exp_seq, (i % 2) == 1), -1);
		end
		check_counts();
		end_test();

		begin_test("repeated sequence bits");
		send_and_wait(make_pkt(~m_exp_seq, 1'b0), -1);
		for (int i = 0; i < 6; i++) begin
			send_and_wait(make_pkt($urandom_range(0, 1) ? ~m_exp_seq : m_exp_seq, 1'b1), -1);
		end
		check_counts();
		end_test();

		begin_test("update back-pressure");
		stall_en = 1'b1;
		for (int i = 0; i < 8; i++) begin
			send_and_wait(make_pkt(m_exp_seq, 1'b0), -1);
		end
		wait_for("update", m_pkts);
		stall_en = 1'b0;
		check_counts();
		end_test();

		begin_test("handshake headers");
		repeat (3) send_head(1'b1, 1'b0, $urandom_range(0, 1));
		send_head(1'b0, 1'b0, 1'b1);
		send_head(1'b1, 1'b1, 1'b0);
		check_counts();
		send_head(1'b0, 1'b1, 1'b0);
		send_head(1'b1, 1'b1, 1'b1);
		send_head(1'b1, 1'b0, $urandom_range(0, 1));
		check_counts();
		end_test();

		begin_test("silent lane flush");
		send_and_wait(make_pkt(m_exp_seq, 1'b0), $urandom_range(0, `LINK_DATA_LANES - 1));
		send_and_wait(make_pkt(m_exp_seq, 1'b0), -1);
		check_counts();
		end_test();

		begin_test("game_active clear");
		send_and_wait(make_pkt(m_exp_seq, 1'b0), -1);
		// expected bit left at 1 so its clear is visible
		if (!m_exp_seq) begin
			send_and_wait(make_pkt(m_exp_seq, 1'b0), -1);
		end
		game_active = 1'b0;
		repeat (3) @(negedge clk);
		m_exp_seq = 1'b0;
		m_lost = 1'b0;
		m_pkts = 0;
		m_drops = 0;
		m_acks = 0;
		upd_seen = 0;
		check_flag("upd_valid", upd_valid, 1'b0);
		check_flag("ack_seq", ack_seq, 1'b0);
		check_update(opp_garbage, '0, opp_hold, BLANK, opp_queue, '0, opp_playfield, '0);
		check_counts();
		game_active = 1'b1;
		repeat (2) @(negedge clk);
		// sequence 0 accepted again after the clear
		send_and_wait(make_pkt(1'b0, 1'b0), -1);
		check_counts();
		end_test();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: link_rx.f
+incdir+src
src/game_pkg.sv
src/link_pkg.sv
src/lane_deserializer.sv
src/frame_ctrl.sv
src/packet_assembler.sv
src/handshake_decoder.sv
src/link_rx_top.sv
test/link_rx_asserts.sv
test/link_rx_tb.sv

// File: Bender.yml
package:
  name: link_rx

sources:
  - include_dirs:
      - src
    files:
      - src/game_pkg.sv
      - src/link_pkg.sv
      - src/lane_deserializer.sv
      - src/frame_ctrl.sv
      - src/packet_assembler.sv
      - src/handshake_decoder.sv
      - src/link_rx_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/link_rx_asserts.sv
      - test/link_rx_tb.sv
